// ==== rtl/uart_pkg.sv ====
// serial port common definitions
// register map, interrupt identifiers, widths and reset values
`default_nettype none

package uart_pkg;

  // datapath widths
  localparam int DATA_W     = 8;
  localparam int DIV_W      = 16;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // register reset values
  localparam logic [DATA_W-1:0] LCR_RESET = 8'h00;
  localparam logic [DATA_W-1:0] LSR_RESET = 8'h60;
  localparam logic [DATA_W-1:0] DLL_RESET = 8'h60;
  localparam logic [DATA_W-1:0] DLM_RESET = 8'h80;
  localparam logic [DATA_W-1:0] IIR_RESET = 8'hC1;

  // register offsets with DLL/DLM at 0 and 1 under DLAB
  typedef enum logic [2:0] {
    REG_RBR = 3'd0,
    REG_IER = 3'd1,
    REG_IIR = 3'd2,
    REG_LCR = 3'd3,
    REG_MCR = 3'd4,
    REG_LSR = 3'd5,
    REG_MSR = 3'd6,
    REG_SCR = 3'd7
  } reg_addr_e;

  // IIR bits 3:1
  typedef enum logic [2:0] {
    IRQ_NONE      = 3'd0,
    IRQ_THR_EMPTY = 3'd1,
    IRQ_RX_DATA   = 3'd2,
    IRQ_LINE      = 3'd3
  } irq_id_e;

endpackage

`default_nettype wire

// ==== rtl/uart_fifo.sv ====
// byte FIFO, circular buffer with read and write pointers
// head entry is always visible on dout
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
  import uart_pkg::*;
#(
  parameter int FIFO_DEPTH = uart_pkg::FIFO_DEPTH
)
(
  input  wire logic              baudclk_24000kHz,
  input  wire logic              reset,
  input  wire logic              push,
  input  wire logic [DATA_W-1:0] din,
  input  wire logic              pop,
  output logic      [DATA_W-1:0] dout,
  output logic                   empty,
  output logic                   full
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wptr;
  logic [FIFO_AW-1:0] rptr;
  logic [FIFO_AW:0]   count;
  logic               do_push;
  logic               do_pop;

  assign empty = (count == '0);
  assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  // overflow and underflow are ignored
  assign do_push = push && !full;
  assign do_pop = pop && !empty;
  assign dout = mem[rptr];

  always_ff @(posedge baudclk_24000kHz)
  begin
    if (do_push)
      mem[wptr] <= din;
  end

  always_ff @(posedge baudclk_24000kHz or negedge reset)
  begin
    if (!reset)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wptr <= (wptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (do_pop)
        rptr <= (rptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
// serial transmitter
// builds a frame from the FIFO head and shifts it out LSB first
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  wire logic              baudclk_24000kHz,
  input  wire logic              reset,
  input  wire logic [4:0]        lcr,
  input  wire logic [DIV_W-1:0]  divisor,
  input  wire logic              empty,
  input  wire logic [DATA_W-1:0] head,
  output logic                   pop,
  output logic                   busy,
  output logic                   tx
);

  logic [3:0]        word_len;
  logic [3:0]        frame_len;
  logic [DATA_W-1:0] data_bits;
  logic              parity;
  logic [11:0]       frame;
  logic [11:0]       shift_q;
  logic [3:0]        bits_left;
  logic [DIV_W-1:0]  baud_cnt;

  assign word_len = 4'd5 + {2'b00, lcr[1:0]};
  // start + data + parity + one or two stop bits
  assign frame_len = 4'd2 + word_len + {3'b000, lcr[3]} + {3'b000, lcr[2]};
  assign pop = !empty && !busy;
  assign tx = shift_q[0];

  always_comb
  begin
    data_bits = head & ({DATA_W{1'b1}} >> (4'd8 - word_len));
    // odd parity unless even is selected
    parity = (^data_bits) ^ ~lcr[4];
    frame = '1;
    frame[0] = 1'b0;
    for (int i = 0; i < DATA_W; i++)
    begin
      if (i < word_len)
        frame[i + 1] = head[i];
    end
    if (lcr[3])
      frame[word_len + 4'd1] = parity;
  end

  //////////////////////////////////////////////////
  // bit-rate counter and shifter
  always_ff @(posedge baudclk_24000kHz or negedge reset)
  begin
    if (!reset)
    begin
      shift_q   <= '1;
      bits_left <= '0;
      baud_cnt  <= '0;
      busy      <= 1'b0;
    end
    else if (pop)
    begin
      shift_q   <= frame;
      bits_left <= frame_len;
      baud_cnt  <= divisor - 1'b1;
      busy      <= 1'b1;
    end
    else if (busy)
    begin
      if (baud_cnt == '0)
      begin
        baud_cnt  <= divisor - 1'b1;
        shift_q   <= {1'b1, shift_q[11:1]};
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1)
          busy <= 1'b0;
      end
      else
        baud_cnt <= baud_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
// serial receiver
// start-edge detection, mid-bit sampling, parity and stop-bit checks
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  wire logic             baudclk_24000kHz,
  input  wire logic             reset,
  input  wire logic [4:0]       lcr,
  input  wire logic [DIV_W-1:0] divisor,
  input  wire logic             rx,
  output logic                  push,
  output logic [DATA_W-1:0]     data,
  output logic                  parity_err,
  output logic                  framing_err
);

  logic [1:0]       rx_sync;
  logic             rx_bit;
  logic             rx_prev;
  logic             active;
  logic             start_edge;
  logic             sample;
  logic [DIV_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [3:0]       word_len;
  logic [3:0]       stop_idx;
  logic             parity_acc;

  assign rx_bit = rx_sync[1];
  assign word_len = 4'd5 + {2'b00, lcr[1:0]};
  // index 0 is the start bit
  assign stop_idx = word_len + 4'd1 + {3'b000, lcr[3]};
  assign start_edge = !active && rx_prev && !rx_bit;
  assign sample = active && (baud_cnt == '0);

  //////////////////////////////////////////////////
  // frame timing
  always_ff @(posedge baudclk_24000kHz or negedge reset)
  begin
    if (!reset)
    begin
      rx_sync  <= 2'b11;
      rx_prev  <= 1'b1;
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      push     <= 1'b0;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_bit;
      push <= sample && (bit_idx == stop_idx);
      if (start_edge)
      begin
        active   <= 1'b1;
        baud_cnt <= (divisor >> 1) - 1'b1;
        bit_idx  <= '0;
      end
      else if (sample)
      begin
        baud_cnt <= divisor - 1'b1;
        bit_idx  <= bit_idx + 1'b1;
        // false start or end of frame
        if (((bit_idx == '0) && rx_bit) || (bit_idx == stop_idx))
          active <= 1'b0;
      end
      else if (active)
        baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // data and error capture
  always_ff @(posedge baudclk_24000kHz)
  begin
    if (start_edge)
    begin
      data        <= '0;
      parity_acc  <= 1'b0;
      parity_err  <= 1'b0;
      framing_err <= 1'b0;
    end
    else if (sample)
    begin
      if ((bit_idx >= 4'd1) && (bit_idx <= word_len))
      begin
        data[3'(bit_idx - 4'd1)] <= rx_bit;
        parity_acc <= parity_acc ^ rx_bit;
      end
      else if (lcr[3] && (bit_idx == word_len + 4'd1))
        parity_err <= parity_acc ^ rx_bit ^ ~lcr[4];
      else if (bit_idx == stop_idx)
        framing_err <= ~rx_bit;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_regs.sv ====
// serial port register file
// bus decode with DLAB, control and status registers, interrupt priority
`timescale 1ns/1ps
`default_nettype none

module uart_regs
  import uart_pkg::*;
(
  input  wire logic              baudclk_24000kHz,
  input  wire logic              reset,
  input  wire logic              req,
  input  wire logic              we,
  input  wire reg_addr_e         addr,
  input  wire logic [DATA_W-1:0] wdata,
  output logic      [DATA_W-1:0] rdata,
  output logic                   ready,
  input  wire logic              cts_n,
  input  wire logic              dsr_n,
  input  wire logic              ri_n,
  input  wire logic              dcd_n,
  output logic                   rts_n,
  output logic                   dtr_n,
  output logic                   irq_n,
  output logic                   tx_push,
  output logic      [DATA_W-1:0] tx_data,
  input  wire logic              tx_full,
  input  wire logic              tx_empty,
  input  wire logic              tx_busy,
  output logic                   rx_pop,
  input  wire logic [DATA_W-1:0] rx_head,
  input  wire logic              rx_empty,
  input  wire logic              parity_err,
  input  wire logic              framing_err,
  input  wire logic              rx_push,
  output logic      [4:0]        lcr,
  output logic      [DIV_W-1:0]  divisor
);

  logic              pending;
  logic              rd;
  logic              wr;
  logic              dlab;
  logic [3:0]        ier_q;
  logic [DATA_W-1:0] lcr_q;
  logic [4:0]        mcr_q;
  logic [DATA_W-1:0] scr_q;
  logic [DATA_W-1:0] dll_q;
  logic [DATA_W-1:0] dlm_q;
  logic [DATA_W-1:0] lsr_q;
  logic [DATA_W-1:0] iir_q;
  logic [DATA_W-1:0] rbr_q;
  logic [3:0]        modem_s1;
  logic [3:0]        modem_s2;
  logic              pe_q;
  logic              fe_q;
  logic              thre_q;
  logic              tx_empty_d;
  logic              ier_thre_rise;
  irq_id_e           irq_id;
  logic [DATA_W-1:0] rd_mux;

  // access happens in the cycle after req is seen, ready follows it
  assign rd = pending && !we;
  assign wr = pending && we;
  assign dlab = lcr_q[7];

  assign lcr = lcr_q[4:0];
  assign divisor = {dlm_q, dll_q};
  assign tx_data = wdata;
  assign tx_push = wr && (addr == REG_RBR) && !dlab && !tx_full;
  assign rx_pop = rd && (addr == REG_RBR) && !dlab && !rx_empty;
  assign ier_thre_rise = wr && (addr == REG_IER) && !dlab && wdata[1] && !ier_q[1];

  assign rts_n = ~mcr_q[1];
  assign dtr_n = ~mcr_q[0];
  // OUT2 gates the interrupt pin
  assign irq_n = ~(mcr_q[3] && !iir_q[0]);

  //////////////////////////////////////////////////
  // interrupt priority
  always_comb
  begin
    if ((pe_q || fe_q) && ier_q[2])
      irq_id = IRQ_LINE;
    else if (!rx_empty && ier_q[0])
      irq_id = IRQ_RX_DATA;
    else if (thre_q && ier_q[1])
      irq_id = IRQ_THR_EMPTY;
    else
      irq_id = IRQ_NONE;
  end

  // read data select
  always_comb
  begin
    rd_mux = '0;
    case (addr)
      REG_RBR: rd_mux = dlab ? dll_q : (rx_empty ? rbr_q : rx_head);
      REG_IER: rd_mux = dlab ? dlm_q : {4'b0000, ier_q};
      REG_IIR: rd_mux = iir_q;
      REG_LCR: rd_mux = lcr_q;
      REG_MCR: rd_mux = {3'b000, mcr_q};
      REG_LSR: rd_mux = lsr_q;
      REG_MSR: rd_mux = {~modem_s2, 4'b0000};
      REG_SCR: rd_mux = scr_q;
      default: rd_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  always_ff @(posedge baudclk_24000kHz or negedge reset)
  begin
    if (!reset)
    begin
      pending    <= 1'b0;
      ready      <= 1'b0;
      rdata      <= '0;
      ier_q      <= '0;
      lcr_q      <= LCR_RESET;
      mcr_q      <= '0;
      scr_q      <= '0;
      dll_q      <= DLL_RESET;
      dlm_q      <= DLM_RESET;
      lsr_q      <= LSR_RESET;
      iir_q      <= IIR_RESET;
      rbr_q      <= '0;
      modem_s1   <= '1;
      modem_s2   <= '1;
      pe_q       <= 1'b0;
      fe_q       <= 1'b0;
      thre_q     <= 1'b0;
      tx_empty_d <= 1'b1;
    end
    else
    begin
      // a req still high during ready is not a new access
      pending <= req && !pending && !ready;
      ready <= pending;
      if (rd)
        rdata <= rd_mux;
      if (rx_pop)
        rbr_q <= rx_head;

      modem_s1 <= {dcd_n, ri_n, dsr_n, cts_n};
      modem_s2 <= modem_s1;
      tx_empty_d <= tx_empty;

      lsr_q <= {pe_q || fe_q, tx_empty && !tx_busy, tx_empty, 1'b0,
                fe_q, pe_q, 1'b0, !rx_empty};
      iir_q <= {IIR_RESET[7:4], irq_id, irq_id == IRQ_NONE};

      if (wr)
      begin
        case (addr)
          REG_RBR:
          begin
            if (dlab)
              dll_q <= wdata;
          end
          REG_IER:
          begin
            if (dlab)
              dlm_q <= wdata;
            else
              ier_q <= wdata[3:0];
          end
          REG_LCR: lcr_q <= wdata;
          REG_MCR: mcr_q <= wdata[4:0];
          REG_SCR: scr_q <= wdata;
          default: ;
        endcase
      end

      // line errors held until LSR is read
      if (rd && (addr == REG_LSR))
      begin
        pe_q <= 1'b0;
        fe_q <= 1'b0;
      end
      if (rx_push && parity_err)
        pe_q <= 1'b1;
      if (rx_push && framing_err)
        fe_q <= 1'b1;

      // THR empty cleared only when it is the reported source
      if (rd && (addr == REG_IIR) && (iir_q[3:1] == IRQ_THR_EMPTY))
        thre_q <= 1'b0;
      if ((tx_empty && !tx_empty_d) || ier_thre_rise)
        thre_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_16c550.sv ====
// 16C550-style serial port top level
// connects register file, both FIFOs, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_16c550
  import uart_pkg::*;
(
  input  wire logic              baudclk_24000kHz,
  input  wire logic              reset,
  input  wire logic              req,
  input  wire logic              we,
  input  wire reg_addr_e         addr,
  input  wire logic [DATA_W-1:0] wdata,
  output logic      [DATA_W-1:0] rdata,
  output logic                   ready,
  input  wire logic              rx,
  output logic                   tx,
  input  wire logic              cts_n,
  input  wire logic              dsr_n,
  input  wire logic              ri_n,
  input  wire logic              dcd_n,
  output logic                   rts_n,
  output logic                   dtr_n,
  output logic                   irq_n
);

  logic              tx_push;
  logic [DATA_W-1:0] tx_data;
  logic              tx_pop;
  logic [DATA_W-1:0] tx_head;
  logic              tx_full;
  logic              tx_empty;
  logic              tx_busy;
  logic              rx_push;
  logic [DATA_W-1:0] rx_data;
  logic              rx_pop;
  logic [DATA_W-1:0] rx_head;
  logic              rx_empty;
  logic              parity_err;
  logic              framing_err;
  logic [4:0]        lcr;
  logic [DIV_W-1:0]  divisor;

  uart_regs i_uart_regs (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .req              (req),
    .we               (we),
    .addr             (addr),
    .wdata            (wdata),
    .rdata            (rdata),
    .ready            (ready),
    .cts_n            (cts_n),
    .dsr_n            (dsr_n),
    .ri_n             (ri_n),
    .dcd_n            (dcd_n),
    .rts_n            (rts_n),
    .dtr_n            (dtr_n),
    .irq_n            (irq_n),
    .tx_push          (tx_push),
    .tx_data          (tx_data),
    .tx_full          (tx_full),
    .tx_empty         (tx_empty),
    .tx_busy          (tx_busy),
    .rx_pop           (rx_pop),
    .rx_head          (rx_head),
    .rx_empty         (rx_empty),
    .parity_err       (parity_err),
    .framing_err      (framing_err),
    .rx_push          (rx_push),
    .lcr              (lcr),
    .divisor          (divisor)
  );

  // transmit direction
  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_tx_fifo (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .push             (tx_push),
    .din              (tx_data),
    .pop              (tx_pop),
    .dout             (tx_head),
    .empty            (tx_empty),
    .full             (tx_full)
  );

  // receive direction
  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_rx_fifo (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .push             (rx_push),
    .din              (rx_data),
    .pop              (rx_pop),
    .dout             (rx_head),
    .empty            (rx_empty),
    .full             ()
  );

  uart_tx i_uart_tx (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .lcr              (lcr),
    .divisor          (divisor),
    .empty            (tx_empty),
    .head             (tx_head),
    .pop              (tx_pop),
    .busy             (tx_busy),
    .tx               (tx)
  );

  uart_rx i_uart_rx (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .lcr              (lcr),
    .divisor          (divisor),
    .rx               (rx),
    .push             (rx_push),
    .data             (rx_data),
    .parity_err       (parity_err),
    .framing_err      (framing_err)
  );

endmodule

`default_nettype wire

// ==== verification/uart_checker.sv ====
// serial port checker
// reference frame builder, tx line decoder and bus read comparison
`timescale 1ns/1ps
`default_nettype none

module uart_checker
(
  input wire logic        baudclk_24000kHz,
  input wire logic        reset,
  input wire logic        ready,
  input wire logic        we,
  input wire logic [7:0]  rdata,
  input wire logic        tx,
  input wire logic [4:0]  fmt,
  input wire logic [15:0] divisor
);

  int         errors = 0;
  int         test_errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         frames_pending = 0;
  logic       ready_d = 1'b0;
  string      exp_name_q[$];
  logic [7:0] exp_val_q[$];
  logic [7:0] tx_exp_q[$];

  // expected frame as {bit count, bits in line order}
  function automatic logic [15:0] ref_frame(input logic [4:0] f, input logic [7:0] data);
    logic [11:0] bits;
    logic        par;
    int          wlen;
    int          n;
    wlen = 5 + int'(f[1:0]);
    bits = '1;
    bits[0] = 1'b0;
    // odd parity starts from 1
    par = ~f[4];
    for (int i = 0; i < wlen; i++)
    begin
      bits[i + 1] = data[i];
      par = par ^ data[i];
    end
    n = wlen + 1;
    if (f[3])
    begin
      bits[n] = par;
      n = n + 1;
    end
    n = n + (f[2] ? 2 : 1);
    return {n[3:0], bits};
  endfunction

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string name, input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic expect_read(input string name, input logic [7:0] value);
    exp_name_q.push_back(name);
    exp_val_q.push_back(value);
  endtask

  task automatic expect_tx(input logic [7:0] value);
    tx_exp_q.push_back(value);
    frames_pending++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0)
      $display("test %0d %s: pass", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: FAIL, %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // bus reads compared in the ready cycle
  always @(negedge baudclk_24000kHz)
  begin
    string      name;
    logic [7:0] value;
    if (reset && ready && ready_d)
      report_error("ready stayed high for more than one cycle");
    ready_d = ready;
    if (reset && ready && !we && (exp_name_q.size() != 0))
    begin
      name = exp_name_q.pop_front();
      value = exp_val_q.pop_front();
      check_value(name, {4'h0, rdata}, {4'h0, value});
    end
  end

  //////////////////////////////////////////////////
  // tx decoder sampling near mid-bit
  initial
  begin
    logic [15:0] r;
    logic [11:0] got;
    logic [7:0]  b;
    int          n;
    forever
    begin
      @(negedge tx);
      if (reset)
      begin
        if (tx_exp_q.size() == 0)
          report_error("frame on tx with no byte written");
        else
        begin
          b = tx_exp_q.pop_front();
          r = ref_frame(fmt, b);
          n = int'(r[15:12]);
          got = '1;
          repeat (divisor / 2) @(negedge baudclk_24000kHz);
          for (int i = 0; i < n; i++)
          begin
            got[i] = tx;
            if (i < n - 1)
              repeat (divisor) @(negedge baudclk_24000kHz);
          end
          check_value("tx frame", got, r[11:0]);
          frames_pending--;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_uart.sv ====
// serial port testbench
// clock, reset, bus and serial drivers, test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_uart
  import uart_pkg::*;
();

  localparam int DIVISOR       = 4;
  localparam int READY_TIMEOUT = 16;
  localparam int READY_CYCLES  = 3;
  localparam int POLL_LIMIT    = 200;
  localparam int TX_TIMEOUT    = 5000;
  localparam int IRQ_TIMEOUT   = 400;

  logic       baudclk_24000kHz;
  logic       reset;
  logic       req;
  logic       we;
  reg_addr_e  addr;
  logic [7:0] wdata;
  logic [7:0] rdata;
  logic       ready;
  logic       rx;
  logic       tx;
  logic       cts_n;
  logic       dsr_n;
  logic       ri_n;
  logic       dcd_n;
  logic       rts_n;
  logic       dtr_n;
  logic       irq_n;
  logic [4:0] fmt;
  integer     seed;

  uart_16c550 i_uart_16c550 (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .req              (req),
    .we               (we),
    .addr             (addr),
    .wdata            (wdata),
    .rdata            (rdata),
    .ready            (ready),
    .rx               (rx),
    .tx               (tx),
    .cts_n            (cts_n),
    .dsr_n            (dsr_n),
    .ri_n             (ri_n),
    .dcd_n            (dcd_n),
    .rts_n            (rts_n),
    .dtr_n            (dtr_n),
    .irq_n            (irq_n)
  );

  uart_checker i_uart_checker (
    .baudclk_24000kHz (baudclk_24000kHz),
    .reset            (reset),
    .ready            (ready),
    .we               (we),
    .rdata            (rdata),
    .tx               (tx),
    .fmt              (fmt),
    .divisor          (16'(DIVISOR))
  );

  initial
  begin
    baudclk_24000kHz = 1'b0;
    forever #2 baudclk_24000kHz = ~baudclk_24000kHz;
  end

  //////////////////////////////////////////////////
  // bus and serial helpers
  task automatic bus_access(input logic write, input reg_addr_e a, input logic [7:0] d,
                            output logic [7:0] q);
    int   cnt;
    logic seen;
    @(posedge baudclk_24000kHz);
    req <= 1'b1;
    we <= write;
    addr <= a;
    wdata <= d;
    cnt = 0;
    seen = 1'b0;
    while (!seen && (cnt < READY_TIMEOUT))
    begin
      @(negedge baudclk_24000kHz);
      seen = ready;
      cnt++;
    end
    if (!seen)
      i_uart_checker.report_error("bus access got no ready");
    else
      i_uart_checker.check_value("ready latency", 12'(cnt), 12'(READY_CYCLES));
    q = rdata;
    @(posedge baudclk_24000kHz);
    req <= 1'b0;
    we <= 1'b0;
  endtask

  task automatic write_reg(input reg_addr_e a, input logic [7:0] d);
    logic [7:0] q;
    bus_access(1'b1, a, d, q);
  endtask

  task automatic read_expect(input reg_addr_e a, input logic [7:0] exp, input string name);
    logic [7:0] q;
    i_uart_checker.expect_read(name, exp);
    bus_access(1'b0, a, 8'h00, q);
  endtask

  task automatic wait_lsr(input logic [7:0] mask, input logic [7:0] val, input string what);
    logic [7:0] v;
    logic       hit;
    int         cnt;
    hit = 1'b0;
    cnt = 0;
    while (!hit && (cnt < POLL_LIMIT))
    begin
      bus_access(1'b0, REG_LSR, 8'h00, v);
      hit = ((v & mask) == val);
      cnt++;
    end
    if (!hit)
      i_uart_checker.report_error({"LSR never showed ", what});
  endtask

  task automatic wait_irq(input logic level, input string what);
    int cnt;
    cnt = 0;
    while ((irq_n !== level) && (cnt < IRQ_TIMEOUT))
    begin
      @(negedge baudclk_24000kHz);
      cnt++;
    end
    if (irq_n !== level)
      i_uart_checker.report_error({"irq_n stuck while waiting for ", what});
  endtask

  task automatic wait_tx_done();
    int cnt;
    cnt = 0;
    while ((i_uart_checker.frames_pending != 0) && (cnt < TX_TIMEOUT))
    begin
      @(negedge baudclk_24000kHz);
      cnt++;
    end
    if (i_uart_checker.frames_pending != 0)
      i_uart_checker.report_error("transmitted frames did not all appear on tx");
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    i_uart_checker.check_value(name, {11'd0, got}, {11'd0, exp});
  endtask

  // one frame on rx with an optional bad parity or stop bit
  task automatic send_frame(input logic [4:0] f, input logic [7:0] d, input logic bad_par,
                            input logic bad_stop);
    logic [15:0] r;
    logic [11:0] bits;
    int          n;
    int          wlen;
    r = i_uart_checker.ref_frame(f, d);
    bits = r[11:0];
    n = int'(r[15:12]);
    wlen = 5 + int'(f[1:0]);
    if (bad_par)
      bits[wlen + 1] = ~bits[wlen + 1];
    if (bad_stop)
      bits[wlen + 1 + int'(f[3])] = 1'b0;
    for (int i = 0; i < n; i++)
    begin
      @(posedge baudclk_24000kHz);
      rx <= bits[i];
      repeat (DIVISOR - 1) @(posedge baudclk_24000kHz);
    end
    // idle gap
    @(posedge baudclk_24000kHz);
    rx <= 1'b1;
    repeat (DIVISOR - 1) @(posedge baudclk_24000kHz);
  endtask

  task automatic set_format(input logic [4:0] f);
    write_reg(REG_LCR, {3'b000, f});
    fmt <= f;
  endtask

  function automatic logic [7:0] next_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [7:0] word_mask(input logic [4:0] f);
    return 8'hFF >> (2'd3 - f[1:0]);
  endfunction

  //////////////////////////////////////////////////
  // test sequence
  initial
  begin
    logic [7:0] b;
    logic [7:0] rx_bytes [3];
    logic [4:0] tx_formats [5];
    logic [4:0] rx_formats [3];
    tx_formats = '{5'h03, 5'h1B, 5'h0A, 5'h04, 5'h0D};
    rx_formats = '{5'h03, 5'h0A, 5'h04};
    seed = 32'hb4cb;
    reset = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = REG_RBR;
    wdata = 8'h00;
    rx = 1'b1;
    cts_n = 1'b1;
    dsr_n = 1'b1;
    ri_n = 1'b1;
    dcd_n = 1'b1;
    fmt = 5'h00;
    repeat (8) @(posedge baudclk_24000kHz);
    reset <= 1'b1;
    repeat (2) @(posedge baudclk_24000kHz);

    // reset values
    @(negedge baudclk_24000kHz);
    check_pin("irq_n", irq_n, 1'b1);
    check_pin("tx", tx, 1'b1);
    check_pin("rts_n", rts_n, 1'b1);
    check_pin("dtr_n", dtr_n, 1'b1);
    read_expect(REG_LCR, 8'h00, "lcr");
    read_expect(REG_IER, 8'h00, "ier");
    read_expect(REG_MCR, 8'h00, "mcr");
    read_expect(REG_SCR, 8'h00, "scr");
    read_expect(REG_IIR, 8'hC1, "iir");
    read_expect(REG_LSR, 8'h60, "lsr");
    write_reg(REG_LCR, 8'h80);
    read_expect(REG_RBR, 8'h60, "dll");
    read_expect(REG_IER, 8'h80, "dlm");
    write_reg(REG_LCR, 8'h00);
    i_uart_checker.end_test("reset values");

    // register access
    b = next_byte();
    write_reg(REG_SCR, b);
    read_expect(REG_SCR, b, "scr");
    b = next_byte();
    write_reg(REG_IER, b);
    read_expect(REG_IER, b & 8'h0F, "ier");
    write_reg(REG_IER, 8'h00);
    b = next_byte() & 8'h1F;
    write_reg(REG_MCR, b);
    read_expect(REG_MCR, b, "mcr");
    @(negedge baudclk_24000kHz);
    check_pin("rts_n", rts_n, ~b[1]);
    check_pin("dtr_n", dtr_n, ~b[0]);
    write_reg(REG_MCR, 8'h00);
    write_reg(REG_LCR, 8'h80);
    b = next_byte();
    write_reg(REG_RBR, b);
    read_expect(REG_RBR, b, "dll");
    b = next_byte();
    write_reg(REG_IER, b);
    read_expect(REG_IER, b, "dlm");
    write_reg(REG_RBR, 8'(DIVISOR));
    write_reg(REG_IER, 8'h00);
    write_reg(REG_LCR, 8'h00);
    for (int k = 0; k < 2; k++)
    begin
      b = next_byte();
      @(posedge baudclk_24000kHz);
      {dcd_n, ri_n, dsr_n, cts_n} <= b[3:0];
      read_expect(REG_MSR, {~b[3:0], 4'h0}, "msr");
    end
    @(posedge baudclk_24000kHz);
    {dcd_n, ri_n, dsr_n, cts_n} <= 4'hF;
    i_uart_checker.end_test("register access");

    // transmit one burst per format
    for (int f = 0; f < 5; f++)
    begin
      set_format(tx_formats[f]);
      for (int k = 0; k < 4; k++)
      begin
        b = next_byte();
        i_uart_checker.expect_tx(b);
        write_reg(REG_RBR, b);
      end
      wait_tx_done();
      wait_lsr(8'h40, 8'h40, "transmitter idle");
      read_expect(REG_LSR, 8'h60, "lsr");
    end
    i_uart_checker.end_test("transmit");

    // receive
    for (int f = 0; f < 3; f++)
    begin
      set_format(rx_formats[f]);
      for (int k = 0; k < 3; k++)
      begin
        rx_bytes[k] = next_byte();
        send_frame(rx_formats[f], rx_bytes[k], 1'b0, 1'b0);
        wait_lsr(8'h01, 8'h01, "data ready");
      end
      for (int k = 0; k < 3; k++)
      begin
        read_expect(REG_LSR, 8'h61, "lsr");
        read_expect(REG_RBR, rx_bytes[k] & word_mask(rx_formats[f]), "rbr");
      end
      read_expect(REG_LSR, 8'h60, "lsr");
    end
    i_uart_checker.end_test("receive");

    // line errors from parity and then framing
    set_format(5'h1B);
    write_reg(REG_IER, 8'h04);
    write_reg(REG_MCR, 8'h08);
    b = next_byte();
    send_frame(5'h1B, b, 1'b1, 1'b0);
    wait_irq(1'b0, "parity error interrupt");
    read_expect(REG_IIR, 8'hC6, "iir");
    read_expect(REG_LSR, 8'hE5, "lsr");
    read_expect(REG_LSR, 8'h61, "lsr");
    read_expect(REG_RBR, b, "rbr");
    read_expect(REG_IIR, 8'hC1, "iir");
    @(negedge baudclk_24000kHz);
    check_pin("irq_n", irq_n, 1'b1);
    b = next_byte();
    send_frame(5'h1B, b, 1'b0, 1'b1);
    wait_irq(1'b0, "framing error interrupt");
    read_expect(REG_IIR, 8'hC6, "iir");
    read_expect(REG_LSR, 8'hE9, "lsr");
    read_expect(REG_LSR, 8'h61, "lsr");
    read_expect(REG_RBR, b, "rbr");
    write_reg(REG_IER, 8'h00);
    write_reg(REG_MCR, 8'h00);
    i_uart_checker.end_test("line errors");

    // interrupt priority
    set_format(5'h03);
    write_reg(REG_MCR, 8'h08);
    write_reg(REG_IER, 8'h03);
    b = next_byte();
    send_frame(5'h03, b, 1'b0, 1'b0);
    wait_lsr(8'h01, 8'h01, "data ready");
    read_expect(REG_IIR, 8'hC4, "iir");
    read_expect(REG_RBR, b, "rbr");
    read_expect(REG_IIR, 8'hC2, "iir");
    read_expect(REG_IIR, 8'hC1, "iir");
    @(negedge baudclk_24000kHz);
    check_pin("irq_n", irq_n, 1'b1);
    write_reg(REG_IER, 8'h00);
    write_reg(REG_MCR, 8'h00);
    i_uart_checker.end_test("interrupt priority");

    $display("tests %0d, failed %0d, errors %0d", i_uart_checker.tests_run,
             i_uart_checker.tests_failed, i_uart_checker.errors);
    if (i_uart_checker.errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_16c550.sv
verification/uart_checker.sv
verification/tb_uart.sv

// ==== run.sh ====
#!/bin/sh
# build and run the serial port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_uart -f list.f -o sim_uart \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_uart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  exit 0
fi
exit 1
